// File: sources.f
+incdir+logic
logic/fetch_pkg.sv
logic/machine_timer.sv
logic/imem_cache.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
tb/tb_clock.sv
tb/fetch_tb.sv

// File: tb/fetch_tb.sv
`include "fetch_consts.svh"

module fetch_tb;

    localparam logic [31:0] MTVEC = 32'h0000_2100;

    typedef enum logic [2:0] {
        act_none,
        act_branch,
        act_flush,
        act_irq,
        act_timer_ahead,
        act_timer_off,
        act_stall
    } action_e;

    typedef struct packed {
        action_e     action;
        logic [31:0] arg;
        logic [31:0] pc;
        logic        exc;
        logic [3:0]  cause;
        logic        intr;
        logic        until_trap;
    } row_t;

    logic                 clk;
    logic                 reseted;
    logic [31:0]          mtvec;
    fetch_pkg::e2f_t      e2f;
    logic                 irq_ext;
    fetch_pkg::timer_wr_t timer_wr;
    fetch_pkg::imem_wr_t  imem_wr;
    fetch_pkg::f2e_t      f2e;

    row_t                 rows[$];
    logic [31:0]          mtime_ref;

    tb_clock tb_clock_i (
        .clk     (clk),
        .reseted (reseted)
    );

    fetch_top fetch_top_i (
        .clk      (clk),
        .reseted  (reseted),
        .mtvec    (mtvec),
        .e2f      (e2f),
        .irq_ext  (irq_ext),
        .timer_wr (timer_wr),
        .imem_wr  (imem_wr),
        .f2e      (f2e)
    );

    // Reference mtime counting every cycle out of reset
    always @(posedge clk) begin
        if (reseted) begin
            mtime_ref <= 32'd0;
        end else begin
            mtime_ref <= mtime_ref + 32'd1;
        end
    end

    // Preloaded word for a pc or NOP where no word can sit
    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        logic [31:0] off;
        off = pc - `RESET_VECTOR;
        if ((pc[1:0] != 2'b00) || (off >= `IMEM_WORDS * 4)) begin
            return `INSTR_NOP;
        end
        return pc ^ 32'h13;
    endfunction

    task automatic add_row(input action_e action, input logic [31:0] arg, input logic [31:0] pc,
                           input logic exc, input logic [3:0] cause, input logic intr,
                           input logic until_trap);
        row_t r;
        r = {action, arg, pc, exc, cause, intr, until_trap};
        rows.push_back(r);
    endtask

    task automatic fill_table();
        add_row(act_none, 32'h0, `RESET_VECTOR, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, `RESET_VECTOR + 32'h4, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, `RESET_VECTOR + 32'h8, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_branch, 32'h2040, `RESET_VECTOR + 32'hc, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, 32'h2040, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_stall, 32'd6, 32'h2044, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, 32'h2048, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_flush, 32'h0, 32'h204c, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, 32'h2050, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_branch, 32'h2022, 32'h2054, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, 32'h2022, 1'b1, `EXC_INSTR_MISALIGNED, 1'b0, 1'b0);
        add_row(act_none, 32'h0, MTVEC, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_irq, 32'h0, MTVEC + 32'h4, 1'b1, `EXC_EXT_IRQ, 1'b1, 1'b0);
        add_row(act_none, 32'h0, MTVEC, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_timer_ahead, 32'd5, MTVEC + 32'h4, 1'b0, 4'd0, 1'b0, 1'b0);
        // Pc only has to follow the sequence here
        add_row(act_none, 32'h0, 32'h0, 1'b1, `EXC_TIMER_IRQ, 1'b1, 1'b1);
        add_row(act_timer_off, 32'h0, MTVEC, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, MTVEC + 32'h4, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(act_none, 32'h0, MTVEC + 32'h8, 1'b0, 4'd0, 1'b0, 1'b0);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_slot(input int n, input fetch_pkg::f2e_t slot, input logic [31:0] pc,
                              input logic exc, input logic [3:0] cause, input logic intr);
        check_value($sformatf("row %0d pc", n), slot.pc, pc);
        check_value($sformatf("row %0d instr", n), slot.instr, expected_word(pc));
        check_value($sformatf("row %0d exc_start", n), slot.exc_start, exc);
        check_value($sformatf("row %0d cause", n), slot.cause, cause);
        check_value($sformatf("row %0d interrupt flag", n), slot.cause_interrupt, intr);
    endtask

    // Inputs for one row are held until its slot is taken
    task automatic apply_action(input row_t r);
        e2f       = '0;
        e2f.ready = 1'b1;
        irq_ext   = 1'b0;
        timer_wr  = '0;
        case (r.action)
            act_branch: begin
                e2f.branch_taken  = 1'b1;
                e2f.branch_target = r.arg;
            end
            act_flush:       e2f.flush = 1'b1;
            act_irq:         irq_ext = 1'b1;
            act_timer_ahead: timer_wr = '{valid: 1'b1, value: mtime_ref + r.arg};
            act_timer_off:   timer_wr = '{valid: 1'b1, value: '1};
            act_stall:       e2f.ready = 1'b0;
            default: ;
        endcase
    endtask

    // Sampled just after the falling edge drive while f2e is stable
    task automatic await_slot(output fetch_pkg::f2e_t slot);
        int waited;
        waited = 0;
        #1;
        while (!(f2e.exc_start || (e2f.ready && (f2e.instr != `INSTR_NOP)))) begin
            if (waited == 50) begin
                $display("Timeout: no instruction reached execute within 50 cycles");
                $display("=== FAIL ===");
                $fatal(1, "timeout");
            end else begin
                @(negedge clk);
                #1;
                waited++;
            end
        end
        slot = f2e;
    endtask

    initial begin
        fetch_pkg::f2e_t slot;
        logic [31:0]     last_pc;
        logic [31:0]     exp_pc;
        int              seen;

        mtvec    = MTVEC;
        e2f      = '0;
        irq_ext  = 1'b0;
        timer_wr = '0;
        imem_wr  = '0;
        last_pc  = 32'd0;
        fill_table();

        // Preload starts in reset and execute stays stalled until it ends
        @(posedge clk);
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(negedge clk);
            imem_wr.valid = 1'b1;
            imem_wr.addr  = `RESET_VECTOR + i * 4;
            imem_wr.data  = imem_wr.addr ^ 32'h13;
        end
        @(negedge clk);
        imem_wr = '0;

        for (int n = 0; n < rows.size(); n++) begin
            apply_action(rows[n]);
            if (rows[n].action == act_stall) begin
                repeat (rows[n].arg) @(negedge clk);
                e2f.ready = 1'b1;
            end
            exp_pc = rows[n].pc;
            await_slot(slot);
            if (rows[n].until_trap) begin
                seen = 0;
                while (!slot.exc_start) begin
                    check_slot(n, slot, last_pc + 32'd4, 1'b0, 4'd0, 1'b0);
                    last_pc = slot.pc;
                    seen++;
                    if (seen == 8) begin
                        $display("Timer interrupt never reached the execute stage");
                        $display("=== FAIL ===");
                        $fatal(1, "no timer trap");
                    end else begin
                        @(negedge clk);
                        await_slot(slot);
                    end
                end
                exp_pc = last_pc + 32'd4;
            end
            check_slot(n, slot, exp_pc, rows[n].exc, rows[n].cause, rows[n].intr);
            last_pc = slot.pc;
            @(negedge clk);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reseted
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Two rising edges in reset, released on a falling edge
    initial begin
        reseted = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reseted = 1'b0;
    end

endmodule

// File: logic/fetch_top.sv
module fetch_top (
    input  logic                 clk,
    input  logic                 reseted,
    input  logic [31:0]          mtvec,
    input  fetch_pkg::e2f_t      e2f,
    input  logic                 irq_ext,
    input  fetch_pkg::timer_wr_t timer_wr,
    input  fetch_pkg::imem_wr_t  imem_wr,
    output fetch_pkg::f2e_t      f2e
);

    fetch_pkg::cache_req_t cache_req;
    fetch_pkg::cache_rsp_t cache_rsp;
    logic                  irq_timer;

    fetch_ctrl fetch_ctrl_i (
        .clk       (clk),
        .reseted   (reseted),
        .mtvec     (mtvec),
        .cache_rsp (cache_rsp),
        .e2f       (e2f),
        .irq_timer (irq_timer),
        .irq_ext   (irq_ext),
        .cache_req (cache_req),
        .f2e       (f2e)
    );

    // Fixed latency instruction memory
    imem_cache imem_cache_i (
        .clk       (clk),
        .reseted   (reseted),
        .cache_req (cache_req),
        .imem_wr   (imem_wr),
        .cache_rsp (cache_rsp)
    );

    machine_timer machine_timer_i (
        .clk       (clk),
        .reseted   (reseted),
        .timer_wr  (timer_wr),
        .irq_timer (irq_timer)
    );

endmodule

// File: logic/fetch_ctrl.sv
`include "fetch_consts.svh"

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  reseted,
    input  logic [31:0]           mtvec,
    input  fetch_pkg::cache_rsp_t cache_rsp,
    input  fetch_pkg::e2f_t       e2f,
    input  logic                  irq_timer,
    input  logic                  irq_ext,
    output fetch_pkg::cache_req_t cache_req,
    output fetch_pkg::f2e_t       f2e
);

    // FSM state
    logic        boot_pending;
    logic        flushing;
    logic        after_flush;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] saved_instr;

    logic        cache_idle;
    logic        cache_wait;
    logic        cache_done;
    logic        cache_error;
    logic        fetch_go;
    logic        start_flush;
    logic        trap;

    assign cache_idle  = cache_rsp.resp == fetch_pkg::IDLE;
    assign cache_wait  = cache_rsp.resp == fetch_pkg::WAIT;
    assign cache_done  = cache_rsp.resp == fetch_pkg::DONE;
    assign cache_error = (cache_rsp.resp == fetch_pkg::MISALIGNED) ||
                         (cache_rsp.resp == fetch_pkg::ACCESSFAULT);

    always_comb begin
        cache_req.cmd = fetch_pkg::NONE;
        next_pc       = pc;
        fetch_go      = 1'b0;
        start_flush   = 1'b0;
        trap          = 1'b0;

        // Command selection
        if (flushing) begin
            if (!cache_done) begin
                cache_req.cmd = fetch_pkg::FLUSH_ALL;
            end
        end else if (cache_wait) begin
            // Cache ignores this, address stays on pc
            cache_req.cmd = fetch_pkg::EXECUTE;
        end else if (boot_pending || cache_error ||
                     (e2f.ready && (cache_done || cache_idle))) begin
            fetch_go      = 1'b1;
            cache_req.cmd = fetch_pkg::EXECUTE;
            if (boot_pending) begin
                next_pc = `RESET_VECTOR;
            end else if (irq_ext || irq_timer) begin
                trap    = 1'b1;
                next_pc = mtvec;
            end else if (e2f.branch_taken) begin
                next_pc = e2f.branch_target;
            end else if (e2f.flush) begin
                // Flush restarts at pc + 4 once the cache is clean
                cache_req.cmd = fetch_pkg::FLUSH_ALL;
                start_flush   = 1'b1;
            end else if (cache_error) begin
                trap    = 1'b1;
                next_pc = mtvec;
            end else begin
                next_pc = pc + 32'd4;
            end
        end
        cache_req.addr = next_pc;

        // Slot shown to execute
        f2e.instr     = `INSTR_NOP;
        f2e.pc        = pc;
        f2e.exc_start = trap;
        if (cache_done && !flushing) begin
            f2e.instr = cache_rsp.load_data;
        end else if (cache_idle && !after_flush && !boot_pending) begin
            // Held slot while execute stalls
            f2e.instr = saved_instr;
        end

        // Cause, fetch errors win over interrupts
        f2e.cause           = 4'd0;
        f2e.cause_interrupt = 1'b0;
        if (!e2f.exc_start) begin
            if (cache_rsp.resp == fetch_pkg::MISALIGNED) begin
                f2e.cause = `EXC_INSTR_MISALIGNED;
            end else if (cache_rsp.resp == fetch_pkg::ACCESSFAULT) begin
                f2e.cause = `EXC_INSTR_ACCESS;
            end else if (irq_ext) begin
                f2e.cause           = `EXC_EXT_IRQ;
                f2e.cause_interrupt = 1'b1;
            end else if (irq_timer) begin
                f2e.cause           = `EXC_TIMER_IRQ;
                f2e.cause_interrupt = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        saved_instr <= f2e.instr;
        pc          <= next_pc;
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            boot_pending <= 1'b1;
            flushing     <= 1'b0;
            after_flush  <= 1'b0;
        end else if (flushing) begin
            if (cache_done) begin
                flushing    <= 1'b0;
                after_flush <= 1'b1;
            end
        end else if (fetch_go) begin
            boot_pending <= 1'b0;
            after_flush  <= 1'b0;
            if (start_flush) begin
                flushing <= 1'b1;
            end
        end
    end

endmodule

// File: logic/imem_cache.sv
`include "fetch_consts.svh"

module imem_cache (
    input  logic                  clk,
    input  logic                  reseted,
    input  fetch_pkg::cache_req_t cache_req,
    input  fetch_pkg::imem_wr_t   imem_wr,
    output fetch_pkg::cache_rsp_t cache_rsp
);

    localparam int          IDX_W     = $clog2(`IMEM_WORDS);
    localparam int          CNT_W     = $clog2(`IC_WAIT_CYCLES + 1);
    localparam logic [31:0] MEM_BYTES = `IMEM_WORDS * 4;

    logic [31:0]             mem [`IMEM_WORDS];

    fetch_pkg::cache_resp_e  resp_q;
    logic [CNT_W-1:0]        wait_cnt;
    logic [IDX_W-1:0]        idx_q;
    logic [31:0]             data_q;

    logic                    accept;
    logic [31:0]             req_off;
    logic                    req_in_range;
    logic [IDX_W-1:0]        req_idx;
    logic [31:0]             wr_off;
    logic                    wr_in_range;
    logic [IDX_W-1:0]        wr_idx;

    // New commands only outside the wait phase
    assign accept = ((cache_req.cmd == fetch_pkg::EXECUTE) ||
                     (cache_req.cmd == fetch_pkg::FLUSH_ALL)) &&
                    (resp_q != fetch_pkg::WAIT);

    // Addresses below the base wrap to large offsets
    assign req_off      = cache_req.addr - `RESET_VECTOR;
    assign req_in_range = req_off < MEM_BYTES;
    assign req_idx      = req_off[IDX_W+1:2];

    // Preload uses the same byte address map as fetch
    assign wr_off      = imem_wr.addr - `RESET_VECTOR;
    assign wr_in_range = (wr_off < MEM_BYTES) && (imem_wr.addr[1:0] == 2'b00);
    assign wr_idx      = wr_off[IDX_W+1:2];

    assign cache_rsp = '{resp: resp_q, load_data: data_q};

    always_ff @(posedge clk) begin
        if (reseted) begin
            resp_q   <= fetch_pkg::IDLE;
            wait_cnt <= '0;
        end else if (accept) begin
            if (cache_req.cmd == fetch_pkg::FLUSH_ALL) begin
                // Array contents survive a flush
                resp_q   <= fetch_pkg::WAIT;
                wait_cnt <= CNT_W'(`IC_WAIT_CYCLES);
            end else if (cache_req.addr[1:0] != 2'b00) begin
                resp_q <= fetch_pkg::MISALIGNED;
            end else if (!req_in_range) begin
                resp_q <= fetch_pkg::ACCESSFAULT;
            end else begin
                resp_q   <= fetch_pkg::WAIT;
                wait_cnt <= CNT_W'(`IC_WAIT_CYCLES);
            end
        end else if (resp_q == fetch_pkg::WAIT) begin
            wait_cnt <= wait_cnt - CNT_W'(1);
            if (wait_cnt == CNT_W'(1)) begin
                resp_q <= fetch_pkg::DONE;
            end
        end else begin
            resp_q <= fetch_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q <= req_idx;
        end
        // Read on the last wait cycle so data lines up with DONE
        if ((resp_q == fetch_pkg::WAIT) && (wait_cnt == CNT_W'(1))) begin
            data_q <= mem[idx_q];
        end
        if (imem_wr.valid && wr_in_range) begin
            mem[wr_idx] <= imem_wr.data;
        end
    end

endmodule

// File: logic/machine_timer.sv
module machine_timer (
    input  logic                 clk,
    input  logic                 reseted,
    input  fetch_pkg::timer_wr_t timer_wr,
    output logic                 irq_timer
);

    logic [31:0] mtime;
    logic [31:0] mtimecmp;

    always_ff @(posedge clk) begin
        if (reseted) begin
            mtime <= 32'd0;
        end else begin
            mtime <= mtime + 32'd1;
        end
    end

    // All ones keeps the interrupt quiet
    always_ff @(posedge clk) begin
        if (reseted) begin
            mtimecmp <= '1;
        end else if (timer_wr.valid) begin
            mtimecmp <= timer_wr.value;
        end
    end

    // Level interrupt, one cycle behind the compare
    always_ff @(posedge clk) begin
        if (reseted) begin
            irq_timer <= 1'b0;
        end else begin
            irq_timer <= mtime >= mtimecmp;
        end
    end

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // Commands from fetch to the instruction cache
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        EXECUTE   = 2'd1,
        FLUSH_ALL = 2'd2
    } cache_cmd_e;

    // Cache responses, errors are one-cycle pulses
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        WAIT        = 3'd1,
        DONE        = 3'd2,
        MISALIGNED  = 3'd3,
        ACCESSFAULT = 3'd4
    } cache_resp_e;

    typedef struct packed {
        cache_cmd_e  cmd;
        logic [31:0] addr;
    } cache_req_t;

    typedef struct packed {
        cache_resp_e resp;
        logic [31:0] load_data;
    } cache_rsp_t;

    // Slot handed to execute, NOP word when empty
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        logic [3:0]  cause;
        logic        cause_interrupt;
    } f2e_t;

    typedef struct packed {
        logic        ready;
        logic        exc_start;
        logic        flush;
        logic        branch_taken;
        logic [31:0] branch_target;
    } e2f_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] value;
    } timer_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } imem_wr_t;

endpackage

// File: logic/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// First fetch address, also base of the instruction array
`define RESET_VECTOR 32'h0000_2000

// addi x0, x0, 0
`define INSTR_NOP 32'h0000_0013

// mcause codes, low four bits only
`define EXC_INSTR_MISALIGNED 4'd0
`define EXC_INSTR_ACCESS 4'd1
`define EXC_TIMER_IRQ 4'd7
`define EXC_EXT_IRQ 4'd11

// Cache model sizing and latency
`define IC_WAIT_CYCLES 2
`define IMEM_WORDS 256

`endif
